// File: vlog.f
+incdir+source
source/reg_map_pkg.sv
source/bus_wr_capture.sv
source/bus_rd_capture.sv
source/reg_store.sv
source/reg_map_top.sv
verif/reg_map_checker.sv
verif/reg_map_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the register map testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module reg_map_tb \
	--Mdir "$BUILD_DIR" \
	-o reg_map_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

"./$BUILD_DIR/reg_map_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

if ! grep -q "All tests passed!" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

// File: verif/reg_map_tb.sv
`timescale 1ns/100ps

`include "reg_map_cfg.svh"

module reg_map_tb import reg_map_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_IDS = `REG_MEM_SIZE;
	localparam int ROUNDS = 4;
	// word slots that a bus byte address can reach.
	localparam int NUM_SLOTS = (1 << `REG_ADDRW) / 4;
	// reads, write rounds with read-back, fabric pass, acks, collisions.
	localparam int NUM_OPS = NUM_IDS + ROUNDS * (2 * NUM_IDS + 2) + 2 * NUM_IDS + NUM_IDS
		+ 2 * NUM_IDS;

	logic clk;
	logic rst_n;
	logic wa_valid;
	logic wa_ready;
	reg_addr_t wa_addr;
	logic wd_valid;
	logic wd_ready;
	reg_data_t wd_data;
	logic wr_valid;
	logic wr_ready;
	resp_t wr_resp;
	logic ra_valid;
	logic ra_ready;
	reg_addr_t ra_addr;
	logic rd_valid;
	logic rd_ready;
	reg_data_t rd_data;
	resp_t rd_resp;
	logic [NUM_IDS-1:0] rtl_write_reqs;
	reg_data_t [NUM_IDS-1:0] rtl_wd_in;
	logic [NUM_IDS-1:0] rtl_read_reqs;
	reg_data_t [NUM_IDS-1:0] rtl_rd_out;
	logic [NUM_IDS-1:0] fresh_bits;

	reg_data_t model [NUM_IDS];
	logic [NUM_IDS-1:0] model_fresh;
	int errors;

	reg_map_top u_reg_map_top (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// random back-pressure on both response channels.
	always @(negedge clk) begin
		if (rst_n) begin
			wr_ready = ($urandom_range(0, 3) != 0);
			rd_ready = ($urandom_range(0, 3) != 0);
		end
	end

	initial begin
		#(NUM_OPS * 200 * CLK_PERIOD);
		$display("watchdog expired before the tests completed");
		$display("Test failures found");
		$finish;
	end

	function automatic reg_data_t limit_of(input int id);
		if (id >= BURST_ID0 && id < BURST_ID0 + `REG_DAC_NUM)
			return reg_data_t'(`REG_MAX_BURST);
		if (id >= SCALE_ID0 && id < SCALE_ID0 + `REG_DAC_NUM)
			return reg_data_t'(`REG_MAX_SCALE);
		return '1;
	endfunction

	function automatic bit is_writable(input int id);
		return id < `REG_MAPPED_CEIL && id != MAXB_ID && id != VER_ID && id != SIZE_ID;
	endfunction

	function automatic reg_data_t expect_word(input int id);
		if (id == MAXB_ID)
			return reg_data_t'(`REG_MAX_BURST);
		if (id == VER_ID)
			return reg_data_t'(`REG_FW_VERSION);
		if (id == SIZE_ID)
			return reg_data_t'(`REG_MEM_SIZE);
		if (id >= `REG_MAPPED_CEIL)
			return '0;
		return model[id];
	endfunction

	function automatic resp_t expect_resp(input int id);
		return (id >= `REG_MAPPED_CEIL) ? SLVERR : OKAY;
	endfunction

	function automatic reg_data_t rand_word();
		// shifting spreads values across small and large magnitudes.
		return reg_data_t'($urandom >> $urandom_range(0, 31));
	endfunction

	function automatic reg_data_t limited(input int id, input reg_data_t value);
		return (value > limit_of(id)) ? limit_of(id) : value;
	endfunction

	task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s response %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_fresh(input logic [NUM_IDS-1:0] got, input logic [NUM_IDS-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: fresh bits %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_fabric_view();
		@(negedge clk);
		#1;
		for (int i = 0; i < NUM_IDS; i++)
			check_data(rtl_rd_out[i], expect_word(i), $sformatf("rtl_rd_out[%0d]", i));
		check_fresh(fresh_bits, model_fresh);
	endtask

	task automatic take_write_resp(output resp_t resp);
		#1;
		while (!(wr_valid && wr_ready)) begin
			if (wa_ready || wd_ready) begin
				errors++;
				$display("[ERROR] %0t: write channel ready while a response is pending", $time);
			end
			@(negedge clk);
			#1;
		end
		resp = wr_resp;
		@(posedge clk);
	endtask

	task automatic bus_write(input int id, input reg_data_t data, output resp_t resp);
		int da;
		int dd;
		int cyc;
		bit a_done;
		bit d_done;
		bit a_now;
		bit d_now;
		da = $urandom_range(0, 3);
		dd = $urandom_range(0, 3);
		cyc = 0;
		a_done = 0;
		d_done = 0;
		while (!(a_done && d_done)) begin
			@(negedge clk);
			wa_addr = reg_addr_t'(id * 4);
			wd_data = data;
			wa_valid = !a_done && cyc >= da;
			wd_valid = !d_done && cyc >= dd;
			a_now = wa_valid && wa_ready;
			d_now = wd_valid && wd_ready;
			@(posedge clk);
			a_done |= a_now;
			d_done |= d_now;
			cyc++;
		end
		@(negedge clk);
		wa_valid = 0;
		wd_valid = 0;
		take_write_resp(resp);
		if (id < `REG_MAPPED_CEIL)
			model_fresh[id] = 1'b1;
		if (is_writable(id))
			model[id] = limited(id, data);
	endtask

	task automatic bus_read(input int id, output reg_data_t data, output resp_t resp);
		int dly;
		int cyc;
		bit done;
		dly = $urandom_range(0, 3);
		cyc = 0;
		done = 0;
		while (!done) begin
			@(negedge clk);
			ra_addr = reg_addr_t'(id * 4);
			ra_valid = cyc >= dly;
			done = ra_valid && ra_ready;
			@(posedge clk);
			cyc++;
		end
		@(negedge clk);
		ra_valid = 0;
		#1;
		while (!(rd_valid && rd_ready)) begin
			if (ra_ready) begin
				errors++;
				$display("[ERROR] %0t: read address ready while a read is pending", $time);
			end
			@(negedge clk);
			#1;
		end
		data = rd_data;
		resp = rd_resp;
		@(posedge clk);
	endtask

	task automatic read_and_compare(input int id);
		reg_data_t data;
		resp_t resp;
		bus_read(id, data, resp);
		check_data(data, expect_word(id), $sformatf("bus read id %0d", id));
		check_resp(resp, expect_resp(id), $sformatf("bus read id %0d", id));
	endtask

	task automatic fabric_write(input int id, input reg_data_t data);
		@(negedge clk);
		rtl_write_reqs[id] = 1'b1;
		rtl_wd_in[id] = data;
		@(negedge clk);
		rtl_write_reqs = '0;
		if (is_writable(id))
			model[id] = limited(id, data);
	endtask

	task automatic fabric_ack(input int id);
		@(negedge clk);
		rtl_read_reqs[id] = 1'b1;
		@(negedge clk);
		rtl_read_reqs = '0;
		model_fresh[id] = 1'b0;
	endtask

	// bus store write and fabric strobe land on the same edge.
	task automatic collide(input int id, input reg_data_t bus_val, input reg_data_t fab_val);
		resp_t resp;
		@(negedge clk);
		if (!(wa_ready && wd_ready)) begin
			errors++;
			$display("write channel was not idle before the collision on id %0d", id);
		end
		wa_addr = reg_addr_t'(id * 4);
		wd_data = bus_val;
		wa_valid = 1;
		wd_valid = 1;
		@(negedge clk);
		wa_valid = 0;
		wd_valid = 0;
		rtl_write_reqs[id] = 1'b1;
		rtl_wd_in[id] = fab_val;
		@(negedge clk);
		rtl_write_reqs = '0;
		take_write_resp(resp);
		check_resp(resp, OKAY, $sformatf("collision write id %0d", id));
		model_fresh[id] = 1'b1;
		model[id] = limited(id, bus_val);
	endtask

	initial begin
		resp_t resp;
		reg_data_t data;
		int alias_id;
		void'($urandom(32'h012877aa));
		clk = 0;
		rst_n = 0;
		wa_valid = 0;
		wa_addr = '0;
		wd_valid = 0;
		wd_data = '0;
		wr_ready = 1;
		ra_valid = 0;
		ra_addr = '0;
		rd_ready = 1;
		rtl_write_reqs = '0;
		rtl_wd_in = '0;
		rtl_read_reqs = '0;
		errors = 0;
		model_fresh = '0;
		for (int i = 0; i < NUM_IDS; i++)
			model[i] = '0;
		repeat (8) @(negedge clk);
		rst_n = 1;

		for (int i = 0; i < NUM_IDS; i++)
			read_and_compare(i);
		check_fabric_view();

		for (int r = 0; r < ROUNDS; r++) begin
			for (int i = 0; i < NUM_IDS; i++) begin
				data = rand_word();
				bus_write(i, data, resp);
				check_resp(resp, expect_resp(i), $sformatf("bus write id %0d", i));
				check_fabric_view();
			end
			for (int i = 0; i < NUM_IDS; i++)
				read_and_compare(i);
			// an address past the map must not reach the word it aliases.
			alias_id = $urandom_range(NUM_IDS, NUM_SLOTS - 1);
			bus_write(alias_id, rand_word(), resp);
			check_resp(resp, expect_resp(alias_id), $sformatf("bus write id %0d", alias_id));
			check_fabric_view();
			read_and_compare(alias_id);
		end

		for (int i = 0; i < NUM_IDS; i++) begin
			fabric_write(i, rand_word());
			check_fabric_view();
		end
		for (int i = 0; i < NUM_IDS; i++)
			read_and_compare(i);

		for (int i = 0; i < NUM_IDS; i++) begin
			fabric_ack(i);
			check_fabric_view();
		end

		for (int i = 0; i < NUM_IDS; i++) begin
			if (is_writable(i)) begin
				collide(i, rand_word(), rand_word());
				check_fabric_view();
				read_and_compare(i);
			end
		end

		$display("closing: %0d errors", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verif/reg_map_checker.sv
`timescale 1ns/100ps

module reg_map_checker import reg_map_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wa_ready,
	input logic wr_valid,
	input logic rd_valid,
	input logic rd_ready,
	input reg_data_t rd_data,
	input resp_t rd_resp
);

	// a reset edge leaves both response channels idle.
	property p_reset_idle;
		@(posedge clk) !rst_n |=> (!wr_valid && !rd_valid);
	endproperty

	// read data may not move while the master holds it off.
	property p_rd_stable;
		@(posedge clk) disable iff (!rst_n)
			(rd_valid && !rd_ready) |=> ($stable(rd_data) && $stable(rd_resp));
	endproperty

	// no new write address while a response is pending.
	property p_wa_blocked;
		@(posedge clk) disable iff (!rst_n)
			wr_valid |-> !wa_ready;
	endproperty

	a_reset_idle: assert property (p_reset_idle)
		else $error("response valid seen after a reset edge");

	a_rd_stable: assert property (p_rd_stable)
		else $error("read data changed under back-pressure");

	a_wa_blocked: assert property (p_wa_blocked)
		else $error("write address accepted while a response is pending");

endmodule

bind reg_map_top reg_map_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.wa_ready(wa_ready),
	.wr_valid(wr_valid),
	.rd_valid(rd_valid),
	.rd_ready(rd_ready),
	.rd_data(rd_data),
	.rd_resp(rd_resp)
);

// File: source/reg_map_top.sv
`timescale 1ns/100ps

`include "reg_map_cfg.svh"

module reg_map_top import reg_map_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wa_valid,
	output logic wa_ready,
	input reg_addr_t wa_addr,
	input logic wd_valid,
	output logic wd_ready,
	input reg_data_t wd_data,
	output logic wr_valid,
	input logic wr_ready,
	output resp_t wr_resp,
	input logic ra_valid,
	output logic ra_ready,
	input reg_addr_t ra_addr,
	output logic rd_valid,
	input logic rd_ready,
	output reg_data_t rd_data,
	output resp_t rd_resp,
	input logic [`REG_MEM_SIZE-1:0] rtl_write_reqs,
	input reg_data_t [`REG_MEM_SIZE-1:0] rtl_wd_in,
	input logic [`REG_MEM_SIZE-1:0] rtl_read_reqs,
	output reg_data_t [`REG_MEM_SIZE-1:0] rtl_rd_out,
	output logic [`REG_MEM_SIZE-1:0] fresh_bits
);

	logic st_wr_en;
	reg_id_t st_wr_id;
	reg_data_t st_wr_data;
	reg_id_t st_rd_id;
	reg_data_t st_rd_data;

	bus_wr_capture u_wr (
		.clk(clk),
		.rst_n(rst_n),
		.wa_valid(wa_valid),
		.wa_addr(wa_addr),
		.wd_valid(wd_valid),
		.wd_data(wd_data),
		.wr_ready(wr_ready),
		.wa_ready(wa_ready),
		.wd_ready(wd_ready),
		.wr_valid(wr_valid),
		.wr_resp(wr_resp),
		.st_wr_en(st_wr_en),
		.st_wr_id(st_wr_id),
		.st_wr_data(st_wr_data)
	);

	bus_rd_capture u_rd (
		.clk(clk),
		.rst_n(rst_n),
		.ra_valid(ra_valid),
		.ra_addr(ra_addr),
		.rd_ready(rd_ready),
		.st_rd_data(st_rd_data),
		.ra_ready(ra_ready),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_resp(rd_resp),
		.st_rd_id(st_rd_id)
	);

	reg_store u_store (
		.clk(clk),
		.rst_n(rst_n),
		.st_wr_en(st_wr_en),
		.st_wr_id(st_wr_id),
		.st_wr_data(st_wr_data),
		.st_rd_id(st_rd_id),
		.rtl_write_reqs(rtl_write_reqs),
		.rtl_wd_in(rtl_wd_in),
		.rtl_read_reqs(rtl_read_reqs),
		.st_rd_data(st_rd_data),
		.rtl_rd_out(rtl_rd_out),
		.fresh_bits(fresh_bits)
	);

endmodule

// File: source/reg_store.sv
`timescale 1ns/100ps

`include "reg_map_cfg.svh"

module reg_store import reg_map_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic st_wr_en,
	input reg_id_t st_wr_id,
	input reg_data_t st_wr_data,
	input reg_id_t st_rd_id,
	input logic [`REG_MEM_SIZE-1:0] rtl_write_reqs,
	input reg_data_t [`REG_MEM_SIZE-1:0] rtl_wd_in,
	input logic [`REG_MEM_SIZE-1:0] rtl_read_reqs,
	output reg_data_t st_rd_data,
	output reg_data_t [`REG_MEM_SIZE-1:0] rtl_rd_out,
	output logic [`REG_MEM_SIZE-1:0] fresh_bits
);

	logic [`REG_MEM_SIZE-1:0] bus_hit;

	function automatic reg_data_t clamp(input reg_data_t value, input reg_data_t limit);
		return (value > limit) ? limit : value;
	endfunction

	genvar i;

	generate
		for (i = 0; i < `REG_MEM_SIZE; i++) begin : g_word
			assign bus_hit[i] = st_wr_en && (st_wr_id == reg_id_t'(i));

			if (i == MAXB_ID) begin : g_maxb
				assign rtl_rd_out[i] = reg_data_t'(`REG_MAX_BURST);
			end else if (i == VER_ID) begin : g_ver
				assign rtl_rd_out[i] = reg_data_t'(`REG_FW_VERSION);
			end else if (i == SIZE_ID) begin : g_size
				assign rtl_rd_out[i] = reg_data_t'(`REG_MEM_SIZE);
			end else if (i >= `REG_MAPPED_CEIL) begin : g_unmapped
				// no storage behind these ids.
				assign rtl_rd_out[i] = '0;
			end else begin : g_rw
				// all ones makes the clamp transparent for plain words.
				localparam reg_data_t LIMIT =
					(i >= BURST_ID0 && i < BURST_ID0 + `REG_DAC_NUM) ?
						reg_data_t'(`REG_MAX_BURST) :
					(i >= SCALE_ID0 && i < SCALE_ID0 + `REG_DAC_NUM) ?
						reg_data_t'(`REG_MAX_SCALE) :
						{`REG_DATAW{1'b1}};

				reg_data_t word;

				// bus side wins over a fabric strobe in the same cycle.
				always_ff @(posedge clk) begin
					if (!rst_n)
						word <= '0;
					else if (bus_hit[i])
						word <= clamp(st_wr_data, LIMIT);
					else if (rtl_write_reqs[i])
						word <= clamp(rtl_wd_in[i], LIMIT);
				end

				assign rtl_rd_out[i] = word;
			end
		end
	endgenerate

	assign st_rd_data = rtl_rd_out[st_rd_id];

	// a bus write sets the bit even when an acknowledge clears it the same cycle.
	always_ff @(posedge clk) begin
		if (!rst_n)
			fresh_bits <= '0;
		else
			fresh_bits <= (fresh_bits & ~rtl_read_reqs) | bus_hit;
	end

endmodule

// File: source/bus_rd_capture.sv
`timescale 1ns/100ps

`include "reg_map_cfg.svh"

module bus_rd_capture import reg_map_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ra_valid,
	input reg_addr_t ra_addr,
	input logic rd_ready,
	input reg_data_t st_rd_data,
	output logic ra_ready,
	output logic rd_valid,
	output reg_data_t rd_data,
	output resp_t rd_resp,
	output reg_id_t st_rd_id
);

	logic pend;
	logic decerr_q;
	reg_id_t id_q;
	logic ra_xfer;

	// one read in flight from address transfer to data transfer.
	assign ra_ready = !pend && !rd_valid;
	assign ra_xfer = ra_valid && ra_ready;
	assign st_rd_id = id_q;

	always_ff @(posedge clk) begin
		if (ra_xfer) begin
			id_q <= ra_addr[2 +: $bits(reg_id_t)];
			decerr_q <= ra_addr >= reg_addr_t'(`REG_MAPPED_CEIL * 4);
		end
		if (pend) begin
			rd_data <= decerr_q ? '0 : st_rd_data;
			rd_resp <= decerr_q ? SLVERR : OKAY;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			pend <= ra_xfer;
			if (pend)
				rd_valid <= 1'b1;
			else if (rd_valid && rd_ready)
				rd_valid <= 1'b0;
		end
	end

endmodule

// File: source/bus_wr_capture.sv
`timescale 1ns/100ps

`include "reg_map_cfg.svh"

module bus_wr_capture import reg_map_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wa_valid,
	input reg_addr_t wa_addr,
	input logic wd_valid,
	input reg_data_t wd_data,
	input logic wr_ready,
	output logic wa_ready,
	output logic wd_ready,
	output logic wr_valid,
	output resp_t wr_resp,
	output logic st_wr_en,
	output reg_id_t st_wr_id,
	output reg_data_t st_wr_data
);

	cap_state_t state;
	reg_addr_t addr_q;
	reg_data_t data_q;
	logic issue;
	logic wa_xfer;
	logic wd_xfer;
	logic mapped;

	assign wa_ready = (state == IDLE) || (state == HAVE_DATA);
	assign wd_ready = (state == IDLE) || (state == HAVE_ADDR);
	assign wa_xfer = wa_valid && wa_ready;
	assign wd_xfer = wd_valid && wd_ready;

	// unmapped range starts at REG_MAPPED_CEIL words.
	assign mapped = addr_q < reg_addr_t'(`REG_MAPPED_CEIL * 4);

	assign st_wr_id = addr_q[2 +: $bits(reg_id_t)];
	assign st_wr_data = data_q;
	assign st_wr_en = issue && mapped;
	assign wr_resp = mapped ? OKAY : SLVERR;

	always_ff @(posedge clk) begin
		if (wa_xfer)
			addr_q <= wa_addr;
		if (wd_xfer)
			data_q <= wd_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			issue <= 1'b0;
			wr_valid <= 1'b0;
		end else begin
			issue <= 1'b0;
			case (state)
				IDLE: begin
					if (wa_xfer && wd_xfer) begin
						state <= RESP;
						issue <= 1'b1;
					end else if (wa_xfer) begin
						state <= HAVE_ADDR;
					end else if (wd_xfer) begin
						state <= HAVE_DATA;
					end
				end
				HAVE_ADDR: begin
					if (wd_xfer) begin
						state <= RESP;
						issue <= 1'b1;
					end
				end
				HAVE_DATA: begin
					if (wa_xfer) begin
						state <= RESP;
						issue <= 1'b1;
					end
				end
				RESP: begin
					// response goes out the cycle after the store write.
					if (issue)
						wr_valid <= 1'b1;
					else if (wr_valid && wr_ready) begin
						wr_valid <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: source/reg_map_pkg.sv
`include "reg_map_cfg.svh"

package reg_map_pkg;

	// one register word and one bus byte address.
	typedef logic [`REG_DATAW-1:0] reg_data_t;
	typedef logic [`REG_ADDRW-1:0] reg_addr_t;

	// word index is the byte address divided by 4.
	typedef logic [$clog2(`REG_MEM_SIZE)-1:0] reg_id_t;

	typedef logic [1:0] resp_t;

	localparam resp_t OKAY = 2'd0;
	localparam resp_t SLVERR = 2'd2;

	typedef enum logic [1:0] {
		IDLE,
		HAVE_ADDR,
		HAVE_DATA,
		RESP
	} cap_state_t;

	// fixed ids of the map.
	localparam reg_id_t RST_ID = 0;
	localparam reg_id_t BURST_ID0 = 1;
	localparam reg_id_t SCALE_ID0 = BURST_ID0 + `REG_DAC_NUM;
	localparam reg_id_t MAXB_ID = SCALE_ID0 + `REG_DAC_NUM;
	localparam reg_id_t VER_ID = MAXB_ID + 1;
	localparam reg_id_t SIZE_ID = VER_ID + 1;

endpackage

// File: source/reg_map_cfg.svh
`ifndef REG_MAP_CFG_SVH
`define REG_MAP_CFG_SVH

// bus geometry.
`define REG_DATAW 32
`define REG_ADDRW 8

// ids from REG_MAPPED_CEIL up are unmapped.
`define REG_MEM_SIZE 16
`define REG_MAPPED_CEIL 14

// board constants.
`define REG_DAC_NUM 2
`define REG_MAX_BURST 1024
`define REG_MAX_SCALE 15
`define REG_FW_VERSION 3

`endif
